/* filelist.f */
src/dac_cfg_pkg.sv
src/wave_pkg.sv
src/dac_frame_if.sv
src/wave_decode.sv
src/dac_serial_exec.sv
src/dac_load_result.sv
src/tlc5620_wave_top.sv
testbench/dac_frame_checker.sv
testbench/tb_tlc5620_wave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TLC5620 sine generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
        --top-module tb_tlc5620_wave \
        -f filelist.f \
        -o sim_tb

./obj_dir/sim_tb

/* src/dac_cfg_pkg.sv */
`default_nettype none

package dac_cfg_pkg;

        // TLC5620 serial command word layout
        typedef logic [7:0]  dac_data_t;        // DAC code D7..D0
        typedef logic [1:0]  dac_chan_t;        // Channel address A1 A0

        // A1 A0 RNG D7..D0, shifted out MSB first
        typedef logic [10:0] dac_cmd_t;

        localparam int CMD_BITS = 11;          // Bits per frame

endpackage

`default_nettype wire

/* src/dac_frame_if.sv */
`timescale 1ns/10ps
`default_nettype none

// One DAC frame passing decode -> execute -> result
interface dac_frame_if;
        import dac_cfg_pkg::*;

        dac_cmd_t cmd;          // Held stable for the whole frame
        logic     start;
        logic     shift_done;
        logic     frame_done;

        modport decode (
                output cmd,
                output start,
                input  frame_done
        );

        modport exec (
                input  cmd,
                input  start,
                output shift_done
        );

        modport result (
                input  shift_done,
                output frame_done
        );

endinterface

`default_nettype wire

/* src/dac_load_result.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_load_result #(
        parameter int STROBE_W = 3
) (
        input  logic            sys_clk,
        input  logic            sys_rst_n,
        dac_frame_if.result     frm,
        output logic            tlc5620_load,
        output logic            tlc5620_ldac
);
        typedef enum logic [1:0] {IDLE, LOAD_LOW, LDAC_LOW, DONE} state_t;

        localparam int CNT_W = $clog2(STROBE_W + 1);

        state_t           state;
        logic [CNT_W-1:0] width_cnt;
        logic             width_end;

        assign width_end      = width_cnt == CNT_W'(STROBE_W - 1);
        assign frm.frame_done = state == DONE;  // Same cycle LDAC goes back high

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        state        <= IDLE;
                        width_cnt    <= '0;
                        tlc5620_load <= 1'b1;
                        tlc5620_ldac <= 1'b1;
                end else begin
                        case (state)
                        IDLE: begin
                                if (frm.shift_done) begin
                                        state        <= LOAD_LOW;
                                        width_cnt    <= '0;
                                        tlc5620_load <= 1'b0;
                                end
                        end
                        LOAD_LOW: begin
                                if (width_end) begin
                                        state        <= LDAC_LOW;
                                        width_cnt    <= '0;
                                        tlc5620_load <= 1'b1;
                                        tlc5620_ldac <= 1'b0;   // Update the output
                                end else begin
                                        width_cnt <= width_cnt + 1'b1;
                                end
                        end
                        LDAC_LOW: begin
                                if (width_end) begin
                                        state        <= DONE;
                                        tlc5620_ldac <= 1'b1;
                                end else begin
                                        width_cnt <= width_cnt + 1'b1;
                                end
                        end
                        default: state <= IDLE;
                        endcase
                end
        end

endmodule

`default_nettype wire

/* src/dac_serial_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_serial_exec #(
        parameter int CLK_DIV = 4
) (
        input  logic            sys_clk,
        input  logic            sys_rst_n,
        dac_frame_if.exec       frm,
        output logic            tlc5620_clk,
        output logic            tlc5620_data
);
        import dac_cfg_pkg::*;

        localparam int DIV_W = $clog2(2 * CLK_DIV);
        localparam int BIT_W = $clog2(CMD_BITS);

        logic             active;
        logic [DIV_W-1:0] div_cnt;      // Position inside one bit
        logic [BIT_W-1:0] bit_cnt;
        logic             bit_end;
        dac_cmd_t         shreg;

        assign bit_end = div_cnt == DIV_W'(2 * CLK_DIV - 1);

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        active         <= 1'b0;
                        div_cnt        <= '0;
                        bit_cnt        <= '0;
                        tlc5620_clk    <= 1'b0;
                        tlc5620_data   <= 1'b0;
                        frm.shift_done <= 1'b0;
                end else begin
                        frm.shift_done <= 1'b0;
                        if (!active) begin
                                if (frm.start) begin
                                        active       <= 1'b1;
                                        div_cnt      <= '0;
                                        bit_cnt      <= '0;
                                        tlc5620_clk  <= 1'b1;
                                        tlc5620_data <= frm.cmd[CMD_BITS-1];
                                end
                        end else if (bit_end) begin
                                div_cnt <= '0;
                                if (bit_cnt == BIT_W'(CMD_BITS - 1)) begin
                                        active         <= 1'b0;
                                        tlc5620_data   <= 1'b0;
                                        frm.shift_done <= 1'b1;
                                end else begin
                                        bit_cnt      <= bit_cnt + 1'b1;
                                        tlc5620_clk  <= 1'b1;
                                        tlc5620_data <= shreg[CMD_BITS-1];
                                end
                        end else begin
                                div_cnt <= div_cnt + 1'b1;
                                if (div_cnt == DIV_W'(CLK_DIV - 1))
                                        tlc5620_clk <= 1'b0;    // Device latches here
                        end
                end
        end

        // Remaining bits, next one always at the MSB
        always_ff @(posedge sys_clk) begin
                if (!active && frm.start)
                        shreg <= frm.cmd << 1;
                else if (active && bit_end)
                        shreg <= shreg << 1;
        end

endmodule

`default_nettype wire

/* src/sine_quarter.hex */
// Quarter-wave amplitude a[k] for k = 0..63, one hex byte per line
02
05
08
0b
0e
11
14
17
1a
1d
20
23
26
29
2c
2f
32
35
38
3a
3d
40
43
45
48
4a
4d
4f
52
54
56
59
5b
5d
5f
61
63
65
67
69
6a
6c
6e
6f
71
72
73
75
76
77
78
79
7a
7b
7c
7c
7d
7d
7e
7e
7f
7f
7f
7f

/* src/tlc5620_wave_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tlc5620_wave_top #(
        parameter int CLK_DIV  = 4,     // sys_clk cycles per serial half period
        parameter int STROBE_W = 3
) (
        input  logic                    sys_clk,
        input  logic                    sys_rst_n,
        input  logic                    enable,
        input  wave_pkg::phase_t        freq_word,
        input  dac_cfg_pkg::dac_chan_t  channel,
        input  logic                    range,
        output logic                    tlc5620_clk,
        output logic                    tlc5620_data,
        output logic                    tlc5620_load,
        output logic                    tlc5620_ldac
);

        dac_frame_if frm ();

        wave_decode u_wave_decode (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .enable    (enable),
                .freq_word (freq_word),
                .channel   (channel),
                .range     (range),
                .frm       (frm.decode)
        );

        dac_serial_exec #(
                .CLK_DIV (CLK_DIV)
        ) u_dac_serial_exec (
                .sys_clk      (sys_clk),
                .sys_rst_n    (sys_rst_n),
                .frm          (frm.exec),
                .tlc5620_clk  (tlc5620_clk),
                .tlc5620_data (tlc5620_data)
        );

        dac_load_result #(
                .STROBE_W (STROBE_W)
        ) u_dac_load_result (
                .sys_clk      (sys_clk),
                .sys_rst_n    (sys_rst_n),
                .frm          (frm.result),
                .tlc5620_load (tlc5620_load),
                .tlc5620_ldac (tlc5620_ldac)
        );

endmodule

`default_nettype wire

/* src/wave_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module wave_decode (
        input  logic                    sys_clk,
        input  logic                    sys_rst_n,
        input  logic                    enable,
        input  wave_pkg::phase_t        freq_word,
        input  dac_cfg_pkg::dac_chan_t  channel,
        input  logic                    range,
        dac_frame_if.decode             frm
);
        import dac_cfg_pkg::*;
        import wave_pkg::*;

        amp_t        rom [QUARTER_DEPTH];
        phase_t      phase;
        phase_t      next_phase;
        wave_index_t idx;
        logic [5:0]  k;
        amp_t        amp;
        dac_data_t   sample;
        logic        busy;
        logic        launch;

        initial begin
                $readmemh(SINE_FILE, rom);
        end

        // Phase steps as the frame closes, so the next word sees it at once
        assign next_phase = frm.frame_done ? phase + freq_word : phase;
        assign idx        = next_phase[15:8];

        // Odd quadrants run the table backwards (63 - k)
        assign k   = idx[5:0] ^ {6{idx[6]}};
        assign amp = rom[k];

        // Upper half above midscale, lower half below
        assign sample = idx[7] ? 8'd127 - {1'b0, amp} : 8'd128 + {1'b0, amp};

        // Line is free when nothing is in flight or the last frame just closed
        assign launch = enable && (!busy || frm.frame_done);

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        phase     <= '0;
                        busy      <= 1'b0;
                        frm.start <= 1'b0;
                end else begin
                        phase     <= next_phase;
                        frm.start <= launch;
                        if (launch)
                                busy <= 1'b1;
                        else if (frm.frame_done)
                                busy <= 1'b0;
                end
        end

        // Channel and range sampled with the word
        always_ff @(posedge sys_clk) begin
                if (launch)
                        frm.cmd <= {channel, range, sample};
        end

endmodule

`default_nettype wire

/* src/wave_pkg.sv */
`default_nettype none

package wave_pkg;

        typedef logic [15:0] phase_t;           // Accumulator and frequency word
        typedef logic [7:0]  wave_index_t;      // Top bits of the phase
        typedef logic [6:0]  amp_t;             // Quarter-wave amplitude

        // Quarter table, one full quadrant
        localparam int    QUARTER_DEPTH = 64;
        localparam string SINE_FILE     = "src/sine_quarter.hex";

endpackage

`default_nettype wire

/* testbench/dac_frame_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_frame_checker (
        input  logic    sys_clk,
        input  logic    sys_rst_n,
        input  logic    start,
        input  logic    frame_done,
        input  logic    tlc5620_clk,
        input  logic    tlc5620_load,
        input  logic    tlc5620_ldac
);
        logic in_flight;

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n)
                        in_flight <= 1'b0;
                else if (start)
                        in_flight <= 1'b1;
                else if (frame_done)
                        in_flight <= 1'b0;
        end

        // One frame at a time
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                start |-> !in_flight)
                else $error("start issued while a frame is in flight");

        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                frame_done |-> in_flight)
                else $error("frame_done without an open frame");

        // Serial clock parked low during the load strobe
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                !tlc5620_load |-> !tlc5620_clk && $stable(tlc5620_clk))
                else $error("serial clock active while load is low");

        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                $fell(tlc5620_ldac) |-> tlc5620_load)
                else $error("LDAC fell before load returned high");

endmodule

bind tlc5620_wave_top dac_frame_checker u_dac_frame_checker (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .start        (frm.start),
        .frame_done   (frm.frame_done),
        .tlc5620_clk  (tlc5620_clk),
        .tlc5620_load (tlc5620_load),
        .tlc5620_ldac (tlc5620_ldac)
);

`default_nettype wire

/* testbench/tb_tlc5620_wave.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tlc5620_wave;
        import dac_cfg_pkg::*;
        import wave_pkg::*;

        localparam int CLK_DIV      = 4;
        localparam int STROBE_W     = 3;
        localparam int FRAME_CYC    = 22 * CLK_DIV + 2 * STROBE_W + 3;
        localparam int SETS         = 6;
        localparam int SET_FRAMES   = 14;
        localparam int TOTAL_FRAMES = 256 + 1 + SETS * (SET_FRAMES + 1);
        localparam int WATCH_CYC    = TOTAL_FRAMES * FRAME_CYC * 2 + 5000;

        logic      sys_clk;
        logic      sys_rst_n;
        logic      enable;
        phase_t    freq_word;
        dac_chan_t channel;
        logic      range;
        logic      tlc5620_clk;
        logic      tlc5620_data;
        logic      tlc5620_load;
        logic      tlc5620_ldac;

        amp_t      quarter [QUARTER_DEPTH];
        int        seed = 32'h1ebf_da50;
        logic      armed = 1'b0;
        phase_t    model_phase = '0;
        dac_cmd_t  rx_word = '0;
        int        rx_bits = 0;
        int        load_cnt = 0;
        int        ldac_cnt = 0;
        int        sclk_edges = 0;

        tlc5620_wave_top #(
                .CLK_DIV  (CLK_DIV),
                .STROBE_W (STROBE_W)
        ) u_tlc5620_wave_top (
                .sys_clk      (sys_clk),
                .sys_rst_n    (sys_rst_n),
                .enable       (enable),
                .freq_word    (freq_word),
                .channel      (channel),
                .range        (range),
                .tlc5620_clk  (tlc5620_clk),
                .tlc5620_data (tlc5620_data),
                .tlc5620_load (tlc5620_load),
                .tlc5620_ldac (tlc5620_ldac)
        );

        initial begin
                sys_clk = 1'b0;
                forever #4 sys_clk = ~sys_clk;
        end

        // Sine rule on the model's own copy of the table
        function automatic dac_cmd_t expected_cmd(input phase_t ph);
                wave_index_t i;
                logic [1:0]  q;
                logic [5:0]  k;
                amp_t        a;
                dac_data_t   s;
                i = ph[15:8];
                q = i[7:6];
                k = i[5:0];
                if (q == 2'd1 || q == 2'd3)     // Mirrored quadrants
                        a = quarter[63 - k];
                else
                        a = quarter[k];
                if (q < 2'd2)
                        s = 8'd128 + 8'(a);
                else
                        s = 8'd127 - 8'(a);     // Below midscale
                return {channel, range, s};
        endfunction

        task automatic check_cmd(input dac_cmd_t exp, input dac_cmd_t act);
                if (act !== exp) begin
                        $display("** Error at %0t: tlc5620_data word expected %03h got %03h",
                                 $time, exp, act);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        endtask

        task automatic check_strobe(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        endtask

        task automatic check_count(input string name, input int exp, input int act);
                if (act != exp) begin
                        $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        endtask

        task automatic tick();
                @(posedge sys_clk);
                #1;
        endtask

        // Serial decoder, the device latches on the falling edge
        always @(posedge tlc5620_clk or negedge tlc5620_clk) begin
                if (armed)
                        sclk_edges++;
        end

        always @(negedge tlc5620_clk) begin
                if (armed) begin
                        rx_word = {rx_word[CMD_BITS-2:0], tlc5620_data};
                        rx_bits++;
                end
        end

        always @(negedge tlc5620_load) begin
                if (armed) begin
                        #1;
                        check_count("bits before load", CMD_BITS, rx_bits);
                        check_strobe("tlc5620_clk", 1'b0, tlc5620_clk);
                        check_strobe("tlc5620_ldac", 1'b1, tlc5620_ldac);
                end
        end

        always @(posedge tlc5620_load) begin
                if (armed) begin
                        check_count("bits per load strobe", CMD_BITS, rx_bits);
                        check_cmd(expected_cmd(model_phase), rx_word);
                        rx_bits = 0;
                        load_cnt++;
                end
        end

        always @(negedge tlc5620_ldac) begin
                if (armed) begin
                        #1;
                        check_strobe("tlc5620_load", 1'b1, tlc5620_load);
                end
        end

        always @(posedge tlc5620_ldac) begin
                if (armed) begin
                        check_count("LDAC pulses", load_cnt, ldac_cnt + 1);
                        ldac_cnt++;
                        model_phase = model_phase + freq_word;   // Frame closed
                end
        end

        task automatic run_set(input phase_t f, input int frames);
                int target;
                int pause;
                int snap;
                freq_word = f;
                channel   = dac_chan_t'($random(seed));
                range     = 1'($random(seed));
                tick();
                enable = 1'b1;
                target = ldac_cnt + frames;
                while (ldac_cnt < target)
                        tick();
                pause = 1 + ($random(seed) & 63);       // Next frame already started
                repeat (pause) tick();
                enable = 1'b0;
                while (ldac_cnt < target + 1)           // Frame in flight still closes
                        tick();
                check_count("frames closed after enable drop", load_cnt, ldac_cnt);
                snap = sclk_edges;
                repeat (40) tick();
                check_count("serial clock edges while idle", snap, sclk_edges);
        endtask

        initial begin
                repeat (WATCH_CYC) @(posedge sys_clk);
                $display("Timeout: the DUT stopped producing frames");
                $display("TEST FAIL");
                $fatal(1);
        end

        initial begin
                $readmemh(SINE_FILE, quarter);
                sys_rst_n = 1'b0;
                enable    = 1'b0;
                freq_word = '0;
                channel   = '0;
                range     = 1'b0;
                repeat (2) @(posedge sys_clk);
                #1;
                sys_rst_n = 1'b1;
                armed     = 1'b1;
                repeat (20) begin
                        tick();
                        check_strobe("tlc5620_clk", 1'b0, tlc5620_clk);
                        check_strobe("tlc5620_data", 1'b0, tlc5620_data);
                        check_strobe("tlc5620_load", 1'b1, tlc5620_load);
                        check_strobe("tlc5620_ldac", 1'b1, tlc5620_ldac);
                end
                run_set(16'd256, 256);          // Every index once
                repeat (SETS)
                        run_set(phase_t'($random(seed)), SET_FRAMES);
                $display("TEST PASS");
                $finish;
        end

endmodule

`default_nettype wire
